/* compile.f */
+incdir+verilog
verilog/axi_sram_pkg.sv
verilog/axi_sram_wr.sv
verilog/axi_sram_rd.sv
verilog/sram_bank.sv
verilog/axi_sram_top.sv
tb/axi_sram_sva.sv
tb/axi_sram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f compile.f --top-module axi_sram_tb -o axi_sram_sim &&
  ./obj_dir/axi_sram_sim ||
  { echo "simulation failed"; exit 1; }

/* tb/axi_sram_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  aw_valid,
  input logic                  aw_ready,
  input axi_sram_pkg::axi_ax_t aw,
  input logic                  w_valid,
  input logic                  w_ready,
  input axi_sram_pkg::axi_w_t  w,
  input logic                  b_valid,
  input logic                  b_ready,
  input axi_sram_pkg::axi_b_t  b,
  input logic                  ar_valid,
  input logic                  ar_ready,
  input axi_sram_pkg::axi_ax_t ar,
  input logic                  r_valid,
  input logic                  r_ready,
  input axi_sram_pkg::axi_r_t  r,
  input logic                  sram_wr_valid,
  input logic                  sram_wr_ready,
  input logic                  sram_rd_valid,
  input logic                  sram_rd_ready
);

  // whoever raises valid holds it and the payload until the transfer
  aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("AW dropped before handshake");
  w_stable: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w)) else $error("W dropped before handshake");
  b_stable: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b)) else $error("B dropped before handshake");
  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else $error("AR dropped before handshake");
  r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r)) else $error("R dropped before handshake");

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !aw_ready && !ar_ready && !b_valid && !r_valid && !sram_wr_valid && !sram_rd_valid)
    else $error("handshake outputs active during reset");

  // the bank serves a single command per cycle
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(sram_wr_valid && sram_wr_ready && sram_rd_valid && sram_rd_ready))
    else $error("bank accepted write and read in the same cycle");

  // a contended grant hands priority to the side that lost
  wr_then_rd: assert property (@(posedge clk) disable iff (!rst_n)
    sram_wr_valid && sram_rd_valid && sram_wr_ready |=> sram_rd_ready)
    else $error("read side not favored after a contended write grant");
  rd_then_wr: assert property (@(posedge clk) disable iff (!rst_n)
    sram_wr_valid && sram_rd_valid && sram_rd_ready |=> sram_wr_ready)
    else $error("write side not favored after a contended read grant");

endmodule

`default_nettype wire

/* tb/axi_sram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_defines.svh"

module axi_sram_tb;
  import axi_sram_pkg::*;

  typedef struct packed {
    logic                       is_write;
    logic                       with_next;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    burst_e                     burst;
    logic [`AXI_STRB_WIDTH-1:0] strb;
  } txn_t;

  localparam int NUM_TXN = 15;

  logic    clk;
  logic    rst_n;
  logic    aw_valid;
  logic    aw_ready;
  axi_ax_t aw;
  logic    w_valid;
  logic    w_ready;
  axi_w_t  w;
  logic    b_valid;
  logic    b_ready;
  axi_b_t  b;
  logic    ar_valid;
  logic    ar_ready;
  axi_ax_t ar;
  logic    r_valid;
  logic    r_ready;
  axi_r_t  r;

  txn_t                       txn_table [NUM_TXN];
  logic [`AXI_DATA_WIDTH-1:0] ref_mem [`SRAM_DEPTH];
  logic [31:0]                lcg_state;
  int                         timeout_cycles;
  int                         total_beats;
  int                         idx;

  axi_sram_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
  );

  bind axi_sram_top axi_sram_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .aw            (aw),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w             (w),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .b             (b),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .ar            (ar),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .r             (r),
    .sram_wr_valid (sram_wr_valid),
    .sram_wr_ready (sram_wr_ready),
    .sram_rd_valid (sram_rd_valid),
    .sram_rd_ready (sram_rd_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [2:0] clamp_size(input logic [2:0] size);
    return (size > 3'(`SRAM_LSB)) ? 3'(`SRAM_LSB) : size;
  endfunction

  // byte lanes a beat of this size covers at this address
  function automatic logic [`AXI_STRB_WIDTH-1:0] lane_mask(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                                           input logic [2:0] size);
    logic [`AXI_STRB_WIDTH-1:0] mask;
    case (size)
      3'd0:    mask = 4'b0001 << addr[1:0];
      3'd1:    mask = addr[1] ? 4'b1100 : 4'b0011;
      default: mask = 4'b1111;
    endcase
    return mask;
  endfunction

  function automatic logic [`AXI_ADDR_WIDTH-1:0] step_addr(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                                           input logic [2:0] size,
                                                           input burst_e burst);
    if (burst == FIXED) begin
      return addr;
    end
    return addr + (`AXI_ADDR_WIDTH'(1) << size);
  endfunction

  task automatic merge_into_model(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                  input logic [`AXI_DATA_WIDTH-1:0] data,
                                  input logic [`AXI_STRB_WIDTH-1:0] strb);
    for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
      if (strb[i]) begin
        ref_mem[addr[`AXI_ADDR_WIDTH-1:`SRAM_LSB]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic do_write(input txn_t t);
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [2:0]                 csize;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic [31:0]                rnd;
    logic                       done;
    addr     = t.addr;
    csize    = clamp_size(t.size);
    aw       = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    aw_valid = 1'b1;
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      data    = next_random();
      strb    = t.strb & lane_mask(addr, csize);
      w       = '{data: data, strb: strb, last: (beat == int'(t.len))};
      w_valid = 1'b1;
      do @(negedge clk); while (!w_ready);
      merge_into_model(addr, data, strb);
      @(posedge clk);
      #1;
      addr = step_addr(addr, csize, t.burst);
    end
    w_valid = 1'b0;
    done    = 1'b0;
    // bready stalls on random cycles
    while (!done) begin
      rnd     = next_random();
      b_ready = rnd[17] | rnd[19];
      @(negedge clk);
      if (b_valid && b_ready) begin
        check_value("bid", 32'(b.id), 32'(t.id));
        check_value("bresp", 32'(b.resp), 32'd0);
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    b_ready = 1'b0;
    // one burst, one response
    @(negedge clk);
    check_value("bvalid after response", 32'(b_valid), 32'd0);
    @(posedge clk);
    #1;
  endtask

  task automatic do_read(input txn_t t);
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [2:0]                 csize;
    logic [31:0]                rnd;
    logic                       done;
    addr     = t.addr;
    csize    = clamp_size(t.size);
    ar       = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    ar_valid = 1'b1;
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      done = 1'b0;
      while (!done) begin
        rnd     = next_random();
        r_ready = rnd[17] | rnd[19];
        @(negedge clk);
        if (r_valid && r_ready) begin
          check_value("rdata", r.data, ref_mem[addr[`AXI_ADDR_WIDTH-1:`SRAM_LSB]]);
          check_value("rid", 32'(r.id), 32'(t.id));
          check_value("rresp", 32'(r.resp), 32'd0);
          check_value("rlast", 32'(r.last), 32'(beat == int'(t.len)));
          done = 1'b1;
        end
        @(posedge clk);
        #1;
      end
      addr = step_addr(addr, csize, t.burst);
    end
    r_ready = 1'b0;
  endtask

  task automatic run_txn(input txn_t t);
    if (t.is_write) begin
      do_write(t);
    end else begin
      do_read(t);
    end
  endtask

  // columns: is_write, with_next, id, addr, len, size, burst, strb
  task automatic load_table();
    txn_table[0]  = '{1'b1, 1'b0, 4'h1, 12'h040, 8'd7, 3'd2, INCR,  4'hf};
    txn_table[1]  = '{1'b0, 1'b0, 4'h2, 12'h040, 8'd7, 3'd2, INCR,  4'hf};
    txn_table[2]  = '{1'b1, 1'b0, 4'h3, 12'h100, 8'd3, 3'd2, FIXED, 4'hf};
    txn_table[3]  = '{1'b0, 1'b0, 4'h4, 12'h100, 8'd3, 3'd2, FIXED, 4'hf};
    txn_table[4]  = '{1'b1, 1'b0, 4'h5, 12'h080, 8'd3, 3'd2, INCR,  4'hf};
    txn_table[5]  = '{1'b1, 1'b0, 4'h6, 12'h080, 8'd3, 3'd2, INCR,  4'h5};
    txn_table[6]  = '{1'b0, 1'b0, 4'h7, 12'h080, 8'd3, 3'd2, INCR,  4'hf};
    txn_table[7]  = '{1'b1, 1'b0, 4'h8, 12'h200, 8'd1, 3'd2, INCR,  4'hf};
    // byte beats that straddle two words
    txn_table[8]  = '{1'b1, 1'b0, 4'h9, 12'h201, 8'd4, 3'd0, INCR,  4'hf};
    txn_table[9]  = '{1'b0, 1'b0, 4'ha, 12'h200, 8'd1, 3'd2, INCR,  4'hf};
    // the next two rows run at the same time
    txn_table[10] = '{1'b1, 1'b1, 4'hb, 12'h300, 8'd5, 3'd2, INCR,  4'hf};
    txn_table[11] = '{1'b0, 1'b0, 4'hc, 12'h040, 8'd7, 3'd2, INCR,  4'hf};
    txn_table[12] = '{1'b0, 1'b0, 4'hd, 12'h300, 8'd5, 3'd2, INCR,  4'hf};
    // size wider than the bus is clamped to one word per beat
    txn_table[13] = '{1'b1, 1'b0, 4'he, 12'h180, 8'd2, 3'd3, INCR,  4'hf};
    txn_table[14] = '{1'b0, 1'b0, 4'hf, 12'h180, 8'd2, 3'd3, INCR,  4'hf};
  endtask

  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("the run timed out before all transactions completed");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    lcg_state      = 32'd55542;
    timeout_cycles = 0;
    rst_n          = 1'b0;
    aw_valid       = 1'b0;
    aw             = '0;
    w_valid        = 1'b0;
    w              = '0;
    b_ready        = 1'b0;
    ar_valid       = 1'b0;
    ar             = '0;
    r_ready        = 1'b0;
    load_table();
    total_beats = 0;
    foreach (txn_table[i]) begin
      total_beats += int'(txn_table[i].len) + 1;
    end
    timeout_cycles = 40 * total_beats + 200;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    idx = 0;
    while (idx < NUM_TXN) begin
      if (txn_table[idx].with_next && idx + 1 < NUM_TXN) begin
        fork
          run_txn(txn_table[idx]);
          run_txn(txn_table[idx + 1]);
        join
        idx += 2;
      end else begin
        run_txn(txn_table[idx]);
        idx += 1;
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/axi_sram_defines.svh */
`ifndef AXI_SRAM_DEFINES_SVH
`define AXI_SRAM_DEFINES_SVH

// byte address width on the AXI side
`define AXI_ADDR_WIDTH 12

// data bus and its byte lanes
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH 4

`define AXI_ID_WIDTH 4

// byte offset bits dropped when forming a word address, also the widest legal size
`define SRAM_LSB 2

// word addressed storage
`define SRAM_ADDR_WIDTH 10
`define SRAM_DEPTH 1024

`endif

/* verilog/axi_sram_pkg.sv */
`default_nettype none

`include "axi_sram_defines.svh"

package axi_sram_pkg;

  // AXI burst encoding, WRAP is accepted but stepped like INCR
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // request fields shared by the AW and AR channels
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    burst_e                     burst;
  } axi_ax_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic                       last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    logic [1:0]               resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                 resp;
    logic                       last;
  } axi_r_t;

  // single word commands towards the bank
  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`AXI_DATA_WIDTH-1:0]  data;
    logic [`AXI_STRB_WIDTH-1:0]  strb;
  } sram_wr_cmd_t;

  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
  } sram_rd_cmd_t;

endpackage

`default_nettype wire

/* verilog/axi_sram_rd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_defines.svh"

module axi_sram_rd (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  axi_sram_pkg::axi_ax_t      ar,
  output logic                       r_valid,
  input  logic                       r_ready,
  output axi_sram_pkg::axi_r_t       r,

  output logic                       sram_rd_valid,
  input  logic                       sram_rd_ready,
  output axi_sram_pkg::sram_rd_cmd_t sram_rd_cmd,
  input  logic                       sram_rd_data_valid,
  input  logic [`AXI_DATA_WIDTH-1:0] sram_rd_data
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_PRESENT
  } state_t;

  state_t                     state;
  state_t                     state_next;

  logic                       ar_ready_next;
  logic                       r_valid_next;
  logic                       r_last;
  logic                       r_last_next;
  logic [`AXI_DATA_WIDTH-1:0] r_data;
  logic [`AXI_DATA_WIDTH-1:0] r_data_next;

  logic [`AXI_ADDR_WIDTH-1:0] rd_addr;
  logic [`AXI_ADDR_WIDTH-1:0] rd_addr_next;
  logic [`AXI_ADDR_WIDTH-1:0] addr_step;
  logic [`AXI_ID_WIDTH-1:0]   rd_id;
  logic [`AXI_ID_WIDTH-1:0]   rd_id_next;
  logic [7:0]                 remaining;
  logic [7:0]                 remaining_next;
  logic [2:0]                 rd_size;
  logic [2:0]                 rd_size_next;
  burst_e                     rd_burst;
  burst_e                     rd_burst_next;

  assign addr_step     = {{(`AXI_ADDR_WIDTH-1){1'b0}}, 1'b1} << rd_size;

  assign sram_rd_valid = (state == ST_ISSUE);
  assign sram_rd_cmd   = '{addr: rd_addr[`AXI_ADDR_WIDTH-1:`SRAM_LSB]};

  assign r             = '{id: rd_id, data: r_data, resp: 2'b00, last: r_last};

  always_comb begin
    state_next     = state;
    rd_addr_next   = rd_addr;
    rd_id_next     = rd_id;
    remaining_next = remaining;
    rd_size_next   = rd_size;
    rd_burst_next  = rd_burst;
    ar_ready_next  = 1'b0;
    r_valid_next   = r_valid;
    r_last_next    = r_last;
    r_data_next    = r_data;

    case (state)
      ST_IDLE: begin
        ar_ready_next = 1'b1;
        if (ar_valid && ar_ready) begin
          state_next     = ST_ISSUE;
          ar_ready_next  = 1'b0;
          rd_addr_next   = ar.addr;
          rd_id_next     = ar.id;
          remaining_next = ar.len;
          rd_size_next   = (ar.size < 3'(`SRAM_LSB)) ? ar.size : 3'(`SRAM_LSB);
          rd_burst_next  = ar.burst;
        end
      end

      ST_ISSUE: begin
        // step the address once the bank has taken the current word
        if (sram_rd_ready) begin
          if (rd_burst != FIXED) begin
            rd_addr_next = rd_addr + addr_step;
          end
          state_next = ST_WAIT;
        end
      end

      ST_WAIT: begin
        if (sram_rd_data_valid) begin
          r_data_next  = sram_rd_data;
          r_valid_next = 1'b1;
          r_last_next  = (remaining == 8'd0);
          state_next   = ST_PRESENT;
        end
      end

      ST_PRESENT: begin
        // next read is only issued after the master has taken this beat
        if (r_ready) begin
          r_valid_next = 1'b0;
          if (r_last) begin
            ar_ready_next = 1'b1;
            state_next    = ST_IDLE;
          end else begin
            remaining_next = remaining - 8'd1;
            state_next     = ST_ISSUE;
          end
        end
      end

      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      state     <= state_next;
      ar_ready  <= ar_ready_next;
      r_valid   <= r_valid_next;
      r_last    <= r_last_next;
      r_data    <= r_data_next;
      rd_addr   <= rd_addr_next;
      rd_id     <= rd_id_next;
      remaining <= remaining_next;
      rd_size   <= rd_size_next;
      rd_burst  <= rd_burst_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_sram_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_defines.svh"

module axi_sram_top (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_sram_pkg::axi_ax_t aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  axi_sram_pkg::axi_w_t  w,
  output logic                  b_valid,
  input  logic                  b_ready,
  output axi_sram_pkg::axi_b_t  b,

  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  axi_sram_pkg::axi_ax_t ar,
  output logic                  r_valid,
  input  logic                  r_ready,
  output axi_sram_pkg::axi_r_t  r
);

  logic                       sram_wr_valid;
  logic                       sram_wr_ready;
  axi_sram_pkg::sram_wr_cmd_t sram_wr_cmd;
  logic                       sram_rd_valid;
  logic                       sram_rd_ready;
  axi_sram_pkg::sram_rd_cmd_t sram_rd_cmd;
  logic                       sram_rd_data_valid;
  logic [`AXI_DATA_WIDTH-1:0] sram_rd_data;

  axi_sram_wr u_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .aw            (aw),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w             (w),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .b             (b),
    .sram_wr_valid (sram_wr_valid),
    .sram_wr_ready (sram_wr_ready),
    .sram_wr_cmd   (sram_wr_cmd)
  );

  axi_sram_rd u_rd (
    .clk                (clk),
    .rst_n              (rst_n),
    .ar_valid           (ar_valid),
    .ar_ready           (ar_ready),
    .ar                 (ar),
    .r_valid            (r_valid),
    .r_ready            (r_ready),
    .r                  (r),
    .sram_rd_valid      (sram_rd_valid),
    .sram_rd_ready      (sram_rd_ready),
    .sram_rd_cmd        (sram_rd_cmd),
    .sram_rd_data_valid (sram_rd_data_valid),
    .sram_rd_data       (sram_rd_data)
  );

  sram_bank u_bank (
    .clk                (clk),
    .rst_n              (rst_n),
    .sram_wr_valid      (sram_wr_valid),
    .sram_wr_ready      (sram_wr_ready),
    .sram_wr_cmd        (sram_wr_cmd),
    .sram_rd_valid      (sram_rd_valid),
    .sram_rd_ready      (sram_rd_ready),
    .sram_rd_cmd        (sram_rd_cmd),
    .sram_rd_data_valid (sram_rd_data_valid),
    .sram_rd_data       (sram_rd_data)
  );

endmodule

`default_nettype wire

/* verilog/axi_sram_wr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_defines.svh"

module axi_sram_wr (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  axi_sram_pkg::axi_ax_t      aw,
  input  logic                       w_valid,
  output logic                       w_ready,
  input  axi_sram_pkg::axi_w_t       w,
  output logic                       b_valid,
  input  logic                       b_ready,
  output axi_sram_pkg::axi_b_t       b,

  output logic                       sram_wr_valid,
  input  logic                       sram_wr_ready,
  output axi_sram_pkg::sram_wr_cmd_t sram_wr_cmd
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_RESP
  } state_t;

  state_t                     state;
  state_t                     state_next;

  logic                       aw_ready_next;
  logic                       b_valid_next;
  logic [`AXI_ID_WIDTH-1:0]   b_id;
  logic [`AXI_ID_WIDTH-1:0]   b_id_next;

  logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
  logic [`AXI_ADDR_WIDTH-1:0] wr_addr_next;
  logic [`AXI_ADDR_WIDTH-1:0] addr_step;
  logic [`AXI_ID_WIDTH-1:0]   wr_id;
  logic [`AXI_ID_WIDTH-1:0]   wr_id_next;
  logic [7:0]                 remaining;
  logic [7:0]                 remaining_next;
  logic [2:0]                 wr_size;
  logic [2:0]                 wr_size_next;
  burst_e                     wr_burst;
  burst_e                     wr_burst_next;

  logic                       burst_active;
  logic                       w_fire;

  assign burst_active  = (state == ST_BURST);
  assign addr_step     = {{(`AXI_ADDR_WIDTH-1){1'b0}}, 1'b1} << wr_size;

  // a beat is taken exactly when the bank accepts its write
  assign w_ready       = burst_active && sram_wr_ready;
  assign w_fire        = w_valid && w_ready;

  assign sram_wr_valid = burst_active && w_valid;
  assign sram_wr_cmd   = '{addr: wr_addr[`AXI_ADDR_WIDTH-1:`SRAM_LSB], data: w.data, strb: w.strb};

  assign b             = '{id: b_id, resp: 2'b00};

  always_comb begin
    state_next     = state;
    wr_addr_next   = wr_addr;
    wr_id_next     = wr_id;
    remaining_next = remaining;
    wr_size_next   = wr_size;
    wr_burst_next  = wr_burst;

    aw_ready_next  = 1'b0;
    b_valid_next   = b_valid && !b_ready;
    b_id_next      = b_id;

    case (state)
      ST_IDLE: begin
        aw_ready_next = 1'b1;
        if (aw_valid && aw_ready) begin
          state_next     = ST_BURST;
          aw_ready_next  = 1'b0;
          wr_addr_next   = aw.addr;
          wr_id_next     = aw.id;
          remaining_next = aw.len;
          // beats wider than the bus are clamped to the bus width
          wr_size_next   = (aw.size < 3'(`SRAM_LSB)) ? aw.size : 3'(`SRAM_LSB);
          wr_burst_next  = aw.burst;
        end
      end

      ST_BURST: begin
        // the beat count ends the burst, wlast is not consulted
        if (w_fire) begin
          if (wr_burst != FIXED) begin
            wr_addr_next = wr_addr + addr_step;
          end
          remaining_next = remaining - 8'd1;
          if (remaining == 8'd0) begin
            if (!b_valid || b_ready) begin
              b_valid_next  = 1'b1;
              b_id_next     = wr_id;
              aw_ready_next = 1'b1;
              state_next    = ST_IDLE;
            end else begin
              state_next = ST_RESP;
            end
          end
        end
      end

      ST_RESP: begin
        // previous response still pending, hold until it drains
        if (!b_valid || b_ready) begin
          b_valid_next  = 1'b1;
          b_id_next     = wr_id;
          aw_ready_next = 1'b1;
          state_next    = ST_IDLE;
        end
      end

      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      aw_ready <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      state     <= state_next;
      aw_ready  <= aw_ready_next;
      b_valid   <= b_valid_next;
      b_id      <= b_id_next;
      wr_addr   <= wr_addr_next;
      wr_id     <= wr_id_next;
      remaining <= remaining_next;
      wr_size   <= wr_size_next;
      wr_burst  <= wr_burst_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_defines.svh"

module sram_bank (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       sram_wr_valid,
  output logic                       sram_wr_ready,
  input  axi_sram_pkg::sram_wr_cmd_t sram_wr_cmd,

  input  logic                       sram_rd_valid,
  output logic                       sram_rd_ready,
  input  axi_sram_pkg::sram_rd_cmd_t sram_rd_cmd,

  output logic                       sram_rd_data_valid,
  output logic [`AXI_DATA_WIDTH-1:0] sram_rd_data
);

  logic [`AXI_DATA_WIDTH-1:0] mem [`SRAM_DEPTH];

  // set when the write port won the most recent grant
  logic last_grant_wr;

  logic wr_fire;
  logic rd_fire;

  // each ready looks only at the other side's request and the priority flag,
  // so with both requesting exactly one of them is high
  assign sram_wr_ready = !sram_rd_valid || !last_grant_wr;
  assign sram_rd_ready = !sram_wr_valid || last_grant_wr;

  assign wr_fire = sram_wr_valid && sram_wr_ready;
  assign rd_fire = sram_rd_valid && sram_rd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant_wr      <= 1'b0;
      sram_rd_data_valid <= 1'b0;
    end else begin
      if (wr_fire) begin
        last_grant_wr <= 1'b1;
      end else if (rd_fire) begin
        last_grant_wr <= 1'b0;
      end
      sram_rd_data_valid <= rd_fire;
    end
  end

  // storage with per byte lane write enables
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
        if (sram_wr_cmd.strb[i]) begin
          mem[sram_wr_cmd.addr][i*8 +: 8] <= sram_wr_cmd.data[i*8 +: 8];
        end
      end
    end
  end

  // read data shows up the cycle after the command is granted
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      sram_rd_data <= mem[sram_rd_cmd.addr];
    end
  end

endmodule

`default_nettype wire
